//--- hdl/cpuPkg.sv
/*
 * Shared core definitions: data and register widths,
 * opcode and function encodings, instruction layout,
 * APB request and response, pipeline stage payloads
 */
package cpuPkg;

	localparam int DBITS = 32;
	localparam int REG_BITS = 4;

	// Control register byte address, bit 0 is run
	localparam logic [11:0] CTRL_ADDR = 12'h100;

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ALUR = 4'd1,
		OP_SW = 4'd5,
		OP_ALUI = 4'd8,
		OP_LW = 4'd9
	} opcodeT;

	typedef enum logic [3:0] {
		FN_ADD = 4'd0,
		FN_SUB = 4'd1,
		FN_AND = 4'd4,
		FN_OR = 4'd5,
		FN_XOR = 4'd6,
		FN_EQ = 4'd8,
		FN_LT = 4'd9
	} funcT;

	// Low 4 bits of imm double as rs2 for register ALU ops
	typedef struct packed {
		opcodeT op;
		funcT func;
		logic [REG_BITS-1:0] rd;
		logic [REG_BITS-1:0] rs1;
		logic [15:0] imm;
	} instT;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [11:0] paddr;
		logic [DBITS-1:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [DBITS-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRspT;

	typedef struct packed {
		logic valid;
		opcodeT op;
		funcT func;
		logic [REG_BITS-1:0] rd;
		logic [REG_BITS-1:0] rs1;
		logic [REG_BITS-1:0] rs2;
		logic [DBITS-1:0] regData1;
		logic [DBITS-1:0] regData2;
		logic [DBITS-1:0] imm;
	} decExT;

	typedef struct packed {
		logic valid;
		opcodeT op;
		logic [REG_BITS-1:0] rd;
		logic [DBITS-1:0] aluResult;
		logic [DBITS-1:0] storeData;
	} exMeT;

	typedef struct packed {
		logic valid;
		logic [REG_BITS-1:0] rd;
		logic [DBITS-1:0] data;
	} wbT;

endpackage

//--- hdl/instMemory.sv
/*
 * Instruction memory behind an APB slave, plus the run
 * control bit and a combinational fetch read port
 */
`timescale 1ns/100ps

module instMemory import cpuPkg::*; #(
	parameter int IMEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	input apbReqT apbReq,
	output apbRspT apbRsp,
	input logic [$clog2(IMEM_WORDS)-1:0] fetchAddr,
	output instT fetchWord,
	output logic run
);

	localparam int IAW = $clog2(IMEM_WORDS);

	logic [DBITS-1:0] mem [IMEM_WORDS];
	// Tracks which words hold real data, the rest read as NOP
	logic [IMEM_WORDS-1:0] written;
	logic access;
	logic memHit;
	logic ctrlHit;
	logic [IAW-1:0] apbIdx;

	assign access = apbReq.psel & apbReq.penable;
	assign memHit = 32'(apbReq.paddr) < 4 * IMEM_WORDS;
	assign ctrlHit = apbReq.paddr == CTRL_ADDR;
	assign apbIdx = apbReq.paddr[IAW+1:2];

	always_ff @(posedge clk) begin
		if (access && apbReq.pwrite && memHit) begin
			mem[apbIdx] <= apbReq.pwdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			written <= '0;
			run <= 1'b0;
		end else if (access && apbReq.pwrite) begin
			if (memHit) begin
				written[apbIdx] <= 1'b1;
			end else if (ctrlHit) begin
				run <= apbReq.pwdata[0];
			end
		end
	end

	// No wait states, error on unmapped addresses
	always_comb begin
		apbRsp.pready = 1'b1;
		apbRsp.pslverr = access && !memHit && !ctrlHit;
		apbRsp.prdata = '0;
		if (memHit) begin
			apbRsp.prdata = written[apbIdx] ? mem[apbIdx] : '0;
		end else if (ctrlHit) begin
			apbRsp.prdata = {{(DBITS-1){1'b0}}, run};
		end
	end

	assign fetchWord = written[fetchAddr] ? instT'(mem[fetchAddr]) : instT'('0);

endmodule

//--- hdl/regFile.sv
/*
 * Sixteen-entry register file, two read ports,
 * one write port with same-cycle bypass
 */
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic [REG_BITS-1:0] rdIdx1,
	input logic [REG_BITS-1:0] rdIdx2,
	output logic [DBITS-1:0] rdData1,
	output logic [DBITS-1:0] rdData2,
	input wbT wr
);

	logic [DBITS-1:0] regs [1 << REG_BITS];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			regs <= '{default: '0};
		end else if (wr.valid) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// Write-through so decode sees the result retiring this cycle
	assign rdData1 = (wr.valid && wr.rd == rdIdx1) ? wr.data : regs[rdIdx1];
	assign rdData2 = (wr.valid && wr.rd == rdIdx2) ? wr.data : regs[rdIdx2];

endmodule

//--- hdl/fetchDecode.sv
/*
 * Program counter, fetch register, instruction decode,
 * immediate sign extension and the decode stage register
 */
`timescale 1ns/100ps

module fetchDecode import cpuPkg::*; #(
	parameter int IMEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input instT fetchWord,
	output logic [$clog2(IMEM_WORDS)-1:0] fetchAddr,
	output logic [REG_BITS-1:0] rdIdx1,
	output logic [REG_BITS-1:0] rdIdx2,
	input logic [DBITS-1:0] rdData1,
	input logic [DBITS-1:0] rdData2,
	output decExT decEx
);

	localparam int IAW = $clog2(IMEM_WORDS);

	logic [IAW-1:0] pc;
	instT fetchReg;
	logic fetchValid;
	logic decodeValid;
	logic [DBITS-1:0] immExt;

	assign fetchAddr = pc;

	// PC holds while stopped, wraps at end of memory
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (run) begin
			pc <= (pc == IAW'(IMEM_WORDS - 1)) ? '0 : pc + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		fetchReg <= fetchWord;
		fetchValid <= run;
		if (!rstN) begin
			fetchValid <= 1'b0;
		end
	end

	// Stores read the data register through port 2
	assign rdIdx1 = fetchReg.rs1;
	assign rdIdx2 = (fetchReg.op == OP_SW) ? fetchReg.rd : fetchReg.imm[REG_BITS-1:0];
	assign immExt = {{(DBITS-16){fetchReg.imm[15]}}, fetchReg.imm};

	// Unknown opcodes fall through as bubbles
	always_comb begin
		case (fetchReg.op)
			OP_ALUR, OP_ALUI, OP_LW, OP_SW: decodeValid = fetchValid;
			default: decodeValid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		decEx.valid <= decodeValid;
		decEx.op <= fetchReg.op;
		decEx.func <= fetchReg.func;
		decEx.rd <= fetchReg.rd;
		decEx.rs1 <= rdIdx1;
		decEx.rs2 <= rdIdx2;
		decEx.regData1 <= rdData1;
		decEx.regData2 <= rdData2;
		decEx.imm <= immExt;
		if (!rstN) begin
			decEx.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/executeStage.sv
/*
 * Execute stage: operand forwarding, ALU with compare
 * flags, and the execute stage register
 */
`timescale 1ns/100ps

module executeStage import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input decExT decEx,
	input wbT memResult,
	input wbT wb,
	output exMeT exMe
);

	logic [DBITS-1:0] opA;
	logic [DBITS-1:0] fwdB;
	logic [DBITS-1:0] aluB;
	logic [DBITS-1:0] aluResult;

	// Youngest producer wins: memory stage, then write-back, then regfile
	function automatic logic [DBITS-1:0] fwdSelect(
		input logic [REG_BITS-1:0] idx,
		input logic [DBITS-1:0] regData,
		input wbT memRes,
		input wbT wbRes
	);
		if (memRes.valid && memRes.rd == idx) begin
			return memRes.data;
		end
		if (wbRes.valid && wbRes.rd == idx) begin
			return wbRes.data;
		end
		return regData;
	endfunction

	assign opA = fwdSelect(decEx.rs1, decEx.regData1, memResult, wb);
	assign fwdB = fwdSelect(decEx.rs2, decEx.regData2, memResult, wb);
	assign aluB = (decEx.op == OP_ALUR) ? fwdB : decEx.imm;

	always_comb begin
		if (decEx.op == OP_LW || decEx.op == OP_SW) begin
			// Address generation
			aluResult = opA + aluB;
		end else begin
			case (decEx.func)
				FN_ADD: aluResult = opA + aluB;
				FN_SUB: aluResult = opA - aluB;
				FN_AND: aluResult = opA & aluB;
				FN_OR: aluResult = opA | aluB;
				FN_XOR: aluResult = opA ^ aluB;
				FN_EQ: aluResult = {{(DBITS-1){1'b0}}, opA == aluB};
				FN_LT: aluResult = {{(DBITS-1){1'b0}}, $signed(opA) < $signed(aluB)};
				default: aluResult = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		exMe.valid <= decEx.valid;
		exMe.op <= decEx.op;
		exMe.rd <= decEx.rd;
		exMe.aluResult <= aluResult;
		// Store data also needs the forwarded value
		exMe.storeData <= fwdB;
		if (!rstN) begin
			exMe.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/memoryStage.sv
/*
 * Memory stage: word-addressed data memory, result
 * select and the write-back register
 */
`timescale 1ns/100ps

module memoryStage import cpuPkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	input exMeT exMe,
	output wbT memResult,
	output wbT wb
);

	localparam int DAW = $clog2(DMEM_WORDS);

	logic [DBITS-1:0] dmem [DMEM_WORDS];
	// Word index, address taken modulo DMEM_WORDS
	logic [DAW-1:0] dmemIdx;

	assign dmemIdx = exMe.aluResult[DAW-1:0];

	always_ff @(posedge clk) begin
		if (exMe.valid && exMe.op == OP_SW) begin
			dmem[dmemIdx] <= exMe.storeData;
		end
	end

	// Combinational read so loads forward without a stall
	assign memResult.valid = exMe.valid && exMe.op != OP_SW;
	assign memResult.rd = exMe.rd;
	assign memResult.data = (exMe.op == OP_LW) ? dmem[dmemIdx] : exMe.aluResult;

	always_ff @(posedge clk) begin
		wb <= memResult;
		if (!rstN) begin
			wb.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/cpuCore.sv
/*
 * Five-stage pipelined core top level with APB load
 * port and write-back report
 */
`timescale 1ns/100ps

module cpuCore import cpuPkg::*; #(
	parameter int IMEM_WORDS = 64,
	parameter int DMEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	input apbReqT apbReq,
	output apbRspT apbRsp,
	output wbT wb
);

	localparam int IAW = $clog2(IMEM_WORDS);

	logic [IAW-1:0] fetchAddr;
	instT fetchWord;
	logic run;
	logic [REG_BITS-1:0] rdIdx1;
	logic [REG_BITS-1:0] rdIdx2;
	logic [DBITS-1:0] rdData1;
	logic [DBITS-1:0] rdData2;
	decExT decEx;
	exMeT exMe;
	wbT memResult;

	instMemory #(.IMEM_WORDS(IMEM_WORDS)) i_instMemory (
		.clk(clk),
		.rstN(rstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.fetchAddr(fetchAddr),
		.fetchWord(fetchWord),
		.run(run)
	);

	regFile i_regFile (
		.clk(clk),
		.rstN(rstN),
		.rdIdx1(rdIdx1),
		.rdIdx2(rdIdx2),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.wr(wb)
	);

	fetchDecode #(.IMEM_WORDS(IMEM_WORDS)) i_fetchDecode (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.fetchWord(fetchWord),
		.fetchAddr(fetchAddr),
		.rdIdx1(rdIdx1),
		.rdIdx2(rdIdx2),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.decEx(decEx)
	);

	// wb doubles as the second forwarding source
	executeStage i_executeStage (
		.clk(clk),
		.rstN(rstN),
		.decEx(decEx),
		.memResult(memResult),
		.wb(wb),
		.exMe(exMe)
	);

	memoryStage #(.DMEM_WORDS(DMEM_WORDS)) i_memoryStage (
		.clk(clk),
		.rstN(rstN),
		.exMe(exMe),
		.memResult(memResult),
		.wb(wb)
	);

endmodule

//--- verif/cpuCore_assert.sv
/*
 * Concurrent checks on the core's APB response
 * and write-back report, bound into cpuCore
 */
`timescale 1ns/100ps

module cpuCoreAssert import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input apbReqT apbReq,
	input apbRspT apbRsp,
	input wbT wb
);

	// Slave never inserts wait states
	apbReadyHigh: assert property (@(posedge clk) apbRsp.pready)
		else $error("APB pready dropped low");

	apbErrInAccess: assert property (@(posedge clk)
		apbRsp.pslverr |-> apbReq.psel && apbReq.penable)
		else $error("APB pslverr raised outside an access phase");

	// Also covers the first cycle out of reset
	wbQuietInReset: assert property (@(posedge clk) !rstN |=> !wb.valid)
		else $error("Write-back valid during or right after reset");

endmodule

bind cpuCore cpuCoreAssert i_coreAssert (
	.clk(clk),
	.rstN(rstN),
	.apbReq(apbReq),
	.apbRsp(apbRsp),
	.wb(wb)
);

//--- verif/cpuTb.sv
/*
 * Core testbench with clock and reset, trace reader,
 * APB driver, write-back checker and final report
 */
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();

	localparam int WB_TIMEOUT = 20;
	localparam int APB_TIMEOUT = 20;
	localparam string TRACE_FILE = "verif/cpuTrace.txt";

	logic clk;
	logic rstN;
	apbReqT apbReq;
	apbRspT apbRsp;
	wbT wb;

	int errors;
	int checks;
	int seed;
	bit runSent;

	cpuCore #(.IMEM_WORDS(64), .DMEM_WORDS(64)) i_dut (
		.clk(clk),
		.rstN(rstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.wb(wb)
	);

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	function automatic void compareValue(input string name,
			input logic [DBITS-1:0] expected, input logic [DBITS-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t %s expected 0x%08h actual 0x%08h",
				$time, name, expected, actual);
		end
	endfunction

	// Gap of 0 to 3 idle cycles before each transfer
	task automatic idleCycles();
		int n;
		n = $random(seed) & 3;
		repeat (n) @(negedge clk);
	endtask

	// Setup phase then access phase from a falling edge
	task automatic apbTransfer(input logic write, input logic [11:0] addr,
			input logic [DBITS-1:0] wdata, output logic [DBITS-1:0] rdata,
			output logic slvErr);
		int cycles;
		bit done;
		idleCycles();
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = write;
		apbReq.paddr = addr;
		apbReq.pwdata = wdata;
		@(negedge clk);
		apbReq.penable = 1'b1;
		cycles = 0;
		done = 1'b0;
		rdata = '0;
		slvErr = 1'b0;
		while (!done && cycles < APB_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (apbRsp.pready) begin
				done = 1'b1;
				rdata = apbRsp.prdata;
				slvErr = apbRsp.pslverr;
			end
		end
		if (!done) begin
			errors++;
			$display("APB access to 0x%03h never saw pready within %0d cycles",
				addr, APB_TIMEOUT);
		end
		apbReq.psel = 1'b0;
		apbReq.penable = 1'b0;
	endtask

	task automatic expectWriteBack(input logic [REG_BITS-1:0] rd,
			input logic [DBITS-1:0] data);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WB_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			seen = wb.valid;
		end
		if (!seen) begin
			errors++;
			$display("Timeout: write-back of r%0d did not arrive within %0d cycles",
				rd, WB_TIMEOUT);
		end else begin
			compareValue("wb.rd", 32'(rd), 32'(wb.rd));
			compareValue("wb.data", data, wb.data);
		end
	endtask

	task automatic checkNoExtraWriteBack();
		repeat (WB_TIMEOUT) begin
			@(negedge clk);
			if (wb.valid) begin
				errors++;
				$display("Unexpected extra write-back of r%0d at %0t", wb.rd, $time);
			end
		end
	endtask

	task automatic runTrace(input int fd);
		int code;
		int ch;
		logic [7:0] cmd;
		logic [DBITS-1:0] arg1;
		logic [DBITS-1:0] arg2;
		logic [DBITS-1:0] rdata;
		logic slvErr;
		bit more;
		more = 1'b1;
		while (more) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1) begin
				more = 1'b0;
			end else if (cmd == "#") begin
				ch = 0;
				while (ch != "\n" && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else if (cmd == "L" || cmd == "R" || cmd == "W") begin
				code = $fscanf(fd, " %h %h", arg1, arg2);
				if (code != 2) begin
					errors++;
					$display("Trace line for command %c is missing arguments", cmd);
					more = 1'b0;
				end else if (cmd == "L") begin
					apbTransfer(1'b1, arg1[11:0], arg2, rdata, slvErr);
					compareValue("apbRsp.pslverr", '0, 32'(slvErr));
				end else if (cmd == "R") begin
					apbTransfer(1'b0, arg1[11:0], '0, rdata, slvErr);
					compareValue("apbRsp.prdata", arg2, rdata);
					compareValue("apbRsp.pslverr", '0, 32'(slvErr));
				end else begin
					expectWriteBack(arg1[REG_BITS-1:0], arg2);
				end
			end else if (cmd == "B") begin
				code = $fscanf(fd, " %h", arg1);
				if (code != 1) begin
					errors++;
					$display("Trace line for command %c is missing its address", cmd);
					more = 1'b0;
				end else begin
					// Unmapped address refuses the write and reads as zero
					apbTransfer(1'b1, arg1[11:0], 32'hA5A5A5A5, rdata, slvErr);
					compareValue("apbRsp.pslverr", 32'd1, 32'(slvErr));
					apbTransfer(1'b0, arg1[11:0], '0, rdata, slvErr);
					compareValue("apbRsp.pslverr", 32'd1, 32'(slvErr));
					compareValue("apbRsp.prdata", '0, rdata);
				end
			end else if (cmd == "G") begin
				runSent = 1'b1;
				apbTransfer(1'b1, CTRL_ADDR, 32'd1, rdata, slvErr);
				compareValue("apbRsp.pslverr", '0, 32'(slvErr));
			end else begin
				errors++;
				$display("Unknown trace command %c", cmd);
				more = 1'b0;
			end
		end
	endtask

	// Nothing may retire until run has been written
	always @(negedge clk) begin
		if (rstN && !runSent && wb.valid) begin
			errors++;
			$display("Write-back of r%0d appeared before the run bit was set", wb.rd);
		end
	end

	initial begin
		int fd;
		seed = 78;
		errors = 0;
		checks = 0;
		runSent = 1'b0;
		rstN = 1'b0;
		apbReq = '0;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open trace file %s", TRACE_FILE);
		end else begin
			runTrace(fd);
			$fclose(fd);
		end
		checkNoExtraWriteBack();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- verilog.f
hdl/cpuPkg.sv
hdl/instMemory.sv
hdl/regFile.sv
hdl/fetchDecode.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuCore.sv
verif/cpuCore_assert.sv
verif/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
	-f verilog.f -o cpuTbSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/cpuTbSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

//--- verif/cpuTrace.txt
# Command letter, then hex arguments: L addr word loads, R addr word reads back,
# B addr probes an unmapped address, G sets run, W reg data expects a write-back
L 000 80100005
L 004 8020FFFD
L 008 10310002
L 00C 11430001
L 010 845400FF
L 014 85650F00
L 018 16760004
L 01C 50700008
L 020 90800008
L 024 80980010
L 028 00000000
L 02C 20110001
L 030 88A10005
L 034 18B10002
L 038 19C20001
L 03C 19D10002
L 040 89E4FFFE
L 044 50C1000B
L 048 90F00010
L 04C 100F0009
L 050 11100005
# Read-back, an unwritten word, run still clear
R 000 80100005
R 020 90800008
R 050 11100005
R 080 00000000
R 100 00000000
B 104
B FFC
G
W 1 00000005
W 2 FFFFFFFD
W 3 00000002
W 4 FFFFFFFD
W 5 000000FD
W 6 00000FFD
W 7 FFFFF000
W 8 FFFFF000
W 9 FFFFF010
W A 00000001
W B 00000000
W C 00000001
W D 00000000
W E 00000001
W F 00000001
W 0 FFFFF011
W 1 FFFFEF14
